//--- Makefile
# Verilator build and run for the UART testbench
TOP       ?= tb_uart
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || { echo "No pass result in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_uart.sv
// UART peripheral testbench
`timescale 1ns/1ps

module tb_uart;

  // Ten bits at divisor 7
  localparam int frame_ns = 10 * 8 * 10;

  logic            clock;
  logic            reset_n;
  uart_pkg::addr_t rw_address;
  uart_pkg::word_t write_data;
  logic            read_request;
  logic            write_request;
  logic            uart_rx;
  uart_pkg::word_t read_data;
  logic            read_response;
  logic            write_response;
  logic            uart_tx;
  logic            uart_irq;
  integer          seed;
  uart_pkg::baud_t divisor;
  uart_pkg::byte_t sent;

  uart_top DUT (.*);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "stopping at the first failure");
  endtask

  // ----------------------------------------------------------------------
  // Register port and serial line
  // ----------------------------------------------------------------------

  task automatic await_response(input logic is_read);
    int cycles = 0;
    do begin
      @(negedge clock);
      cycles++;
    end while (!(is_read ? read_response : write_response) && cycles < 3);
    if (!(is_read ? read_response : write_response)) begin
      abort_run("bus response never arrived");
    end
  endtask

  task automatic bus_write(input uart_pkg::addr_t addr, input uart_pkg::word_t data);
    @(posedge clock);
    rw_address    <= addr;
    write_data    <= data;
    write_request <= 1'b1;
    @(posedge clock);
    write_request <= 1'b0;
    await_response(1'b0);
  endtask

  task automatic bus_read(input uart_pkg::addr_t addr, output uart_pkg::word_t data);
    @(posedge clock);
    rw_address   <= addr;
    read_request <= 1'b1;
    @(posedge clock);
    read_request <= 1'b0;
    await_response(1'b1);
    data = read_data;
  endtask

  // Start bit, data LSB first, stop bit
  task automatic send_frame(input uart_pkg::byte_t data, input int bit_cycles);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clock);
      uart_rx <= frame[i];
      repeat (bit_cycles - 1) @(posedge clock);
    end
    @(posedge clock);
  endtask

  task automatic await_irq(input int limit);
    int cycles = 0;
    while (!uart_irq && cycles < limit) begin
      @(negedge clock);
      cycles++;
    end
    if (!uart_irq) begin
      abort_run("receive interrupt never arrived");
    end
  endtask

  // Stop as soon as a bound assertion fires
  always @(negedge clock) begin
    if (DUT.u_chk.error_count != 0) begin
      abort_run("a bound protocol assertion failed");
    end
  end

  // Room for about 40 frames with a wide margin
  initial begin
    #(frame_ns * 500);
    abort_run("simulation timed out");
  end

  initial begin
    uart_pkg::word_t rdata;
    seed          = 32'ha9b5_f50b;
    reset_n       = 1'b0;
    rw_address    = '0;
    write_data    = '0;
    read_request  = 1'b0;
    write_request = 1'b0;
    uart_rx       = 1'b1;
    repeat (10) @(posedge clock);
    reset_n <= 1'b1;

    divisor = 7;
    bus_write(uart_pkg::uart_baud_addr, divisor);
    bus_read(uart_pkg::uart_baud_addr, rdata);
    bus_read(uart_pkg::uart_status_addr, rdata);

    // Second write lands mid frame and must be dropped
    bus_write(uart_pkg::uart_write_addr, $random(seed));
    bus_read(uart_pkg::uart_status_addr, rdata);
    bus_write(uart_pkg::uart_write_addr, $random(seed));
    for (int i = 0; i < 100 && !rdata[0]; i++) begin
      bus_read(uart_pkg::uart_status_addr, rdata);
    end
    assert (rdata[0]) else abort_run("transmitter never returned to ready");
    repeat (10 * (divisor + 1)) @(posedge clock);

    // Receive, then a frame that arrives while the interrupt is pending
    repeat (4) begin
      sent = 8'($random(seed));
      send_frame(sent, divisor + 1);
      await_irq(20 * (divisor + 1));
      bus_read(uart_pkg::uart_status_addr, rdata);
      assert (rdata[1]) else abort_run($sformatf("FAIL %0t: pending bit clear", $time));
      send_frame(~sent, divisor + 1);
      bus_read(uart_pkg::uart_read_addr, rdata);
      assert (rdata == {24'b0, sent}) else
        abort_run($sformatf("FAIL %0t: read 0x%0h, sent 0x%0h", $time, rdata, sent));
    end

    // Divisor zero holds both datapaths idle
    bus_write(uart_pkg::uart_baud_addr, '0);
    bus_write(uart_pkg::uart_write_addr, 32'h55);
    send_frame(8'ha5, 8);
    repeat (20) @(posedge clock);

    if (DUT.u_chk.error_count == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      abort_run("a bound protocol assertion failed near the end of the run");
    end
  end

endmodule

//--- uart_chk.sv
// UART bound protocol checks
`timescale 1ns/1ps

module uart_chk (
  input logic            clock,
  input logic            reset_n,
  input uart_pkg::addr_t rw_address,
  input uart_pkg::word_t write_data,
  input logic            read_request,
  input logic            write_request,
  input uart_pkg::word_t read_data,
  input logic            read_response,
  input logic            write_response,
  input logic            uart_tx,
  input logic            uart_irq
);

  int              error_count = 0;
  uart_pkg::baud_t shadow_div;
  logic [9:0]      tx_frame;
  int unsigned     tx_cycle;
  logic            tx_busy;
  logic            tx_mid;
  logic            tx_expected;

  // Divisor as last written over the bus
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      shadow_div <= '0;
    end else if (write_request && rw_address == uart_pkg::uart_baud_addr) begin
      shadow_div <= write_data;
    end
  end

  // ----------------------------------------------------------------------
  // Expected transmit frame
  // ----------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (!reset_n || shadow_div == '0) begin
      tx_busy  <= 1'b0;
      tx_cycle <= 0;
    end else if (!tx_busy) begin
      if (write_request && rw_address == uart_pkg::uart_write_addr) begin
        tx_busy  <= 1'b1;
        tx_cycle <= 0;
        tx_frame <= {1'b1, write_data[7:0], 1'b0};
      end
    end else if (tx_cycle == uart_pkg::tx_frame_bits * (shadow_div + 1) - 1) begin
      tx_busy <= 1'b0;
    end else begin
      tx_cycle <= tx_cycle + 1;
    end
  end

  assign tx_mid      = (tx_cycle % (shadow_div + 1)) == (shadow_div / 2);
  assign tx_expected = tx_busy ? tx_frame[tx_cycle / (shadow_div + 1)] : 1'b1;

  a_reset: assert property (@(posedge clock) !reset_n |=> uart_tx && !uart_irq &&
    !read_response && !write_response && read_data == '0) else begin
    error_count++;
    $error("FAIL %0t: outputs not at reset values", $time);
  end

  a_response: assert property (@(posedge clock) disable iff (!reset_n) $past(reset_n) |->
    read_response == $past(read_request) && write_response == $past(write_request)) else begin
    error_count++;
    $error("FAIL %0t: response does not trail its request by one cycle", $time);
  end

  a_baud_read: assert property (@(posedge clock) disable iff (!reset_n)
    read_request && rw_address == uart_pkg::uart_baud_addr |=>
    read_data == $past(shadow_div)) else begin
    error_count++;
    $error("FAIL %0t: baud divisor read back 0x%0h", $time, read_data);
  end

  // Ready means no frame on the line
  a_status_ready: assert property (@(posedge clock) disable iff (!reset_n)
    read_request && rw_address == uart_pkg::uart_status_addr |=>
    read_data[0] == !$past(tx_busy)) else begin
    error_count++;
    $error("FAIL %0t: status ready bit is %0b", $time, read_data[0]);
  end

  a_tx_line: assert property (@(posedge clock) disable iff (!reset_n)
    !tx_busy || tx_mid |-> uart_tx == tx_expected) else begin
    error_count++;
    $error("FAIL %0t: uart_tx is %0b, expected %0b", $time, uart_tx, tx_expected);
  end

  a_irq_off: assert property (@(posedge clock) disable iff (!reset_n)
    (read_request && rw_address == uart_pkg::uart_read_addr) || shadow_div == '0 |=>
    !uart_irq) else begin
    error_count++;
    $error("FAIL %0t: uart_irq high after acknowledge or with divisor zero", $time);
  end

endmodule

bind uart_top uart_chk u_chk (.*);

//--- uart_pkg.sv
// UART shared definitions

package uart_pkg;

  // ----------------------------------------------------------------------
  // Widths that carry a meaning
  // ----------------------------------------------------------------------

  // Register port address
  typedef logic [4:0] addr_t;

  // Bus data word
  typedef logic [31:0] word_t;

  // Serial data byte
  typedef logic [7:0] byte_t;

  // Clock cycles per bit minus one
  typedef logic [31:0] baud_t;

  // ----------------------------------------------------------------------
  // State machines
  // ----------------------------------------------------------------------

  typedef enum logic {
    tx_idle,
    tx_shift
  } tx_state_t;

  // Hunt for start bit, shift in data, wait for acknowledge
  typedef enum logic [1:0] {
    rx_hunt,
    rx_sample,
    rx_hold
  } rx_state_t;

  // ----------------------------------------------------------------------
  // Register map
  // ----------------------------------------------------------------------

  localparam addr_t uart_write_addr  = 5'd0;
  localparam addr_t uart_read_addr   = 5'd4;
  // Bit 0 ready to send, bit 1 interrupt pending
  localparam addr_t uart_status_addr = 5'd8;
  localparam addr_t uart_baud_addr   = 5'd12;

  // Frame geometry
  localparam int tx_frame_bits = 10;
  localparam int rx_data_bits  = 8;

endpackage

//--- uart_regs.sv
// UART register block
`timescale 1ns/1ps

module uart_regs (
  input  logic           clock,
  input  logic           reset_n,
  input  uart_pkg::addr_t rw_address,
  input  uart_pkg::word_t write_data,
  input  logic           read_request,
  input  logic           write_request,
  input  logic           tx_ready,
  input  uart_pkg::byte_t rx_byte,
  input  logic           rx_pending,
  output uart_pkg::word_t read_data,
  output logic           read_response,
  output logic           write_response,
  output uart_pkg::baud_t baud_divisor,
  output logic           tx_start,
  output uart_pkg::byte_t tx_byte,
  output logic           rx_ack
);

  // ----------------------------------------------------------------------
  // Response strobes
  // ----------------------------------------------------------------------

  // Each response trails its request by one cycle
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      read_response  <= 1'b0;
      write_response <= 1'b0;
    end else begin
      read_response  <= read_request;
      write_response <= write_request;
    end
  end

  // ----------------------------------------------------------------------
  // Write decode
  // ----------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      baud_divisor <= '0;
    end else if (write_request && rw_address == uart_pkg::uart_baud_addr) begin
      baud_divisor <= write_data;
    end
  end

  // Serializer decides on its own whether to take the byte
  assign tx_start = write_request && (rw_address == uart_pkg::uart_write_addr);
  assign tx_byte  = write_data[7:0];

  // ----------------------------------------------------------------------
  // Read decode and data mux
  // ----------------------------------------------------------------------

  // Reading the data register acknowledges the interrupt
  assign rx_ack = read_request && (rw_address == uart_pkg::uart_read_addr);

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      read_data <= '0;
    end else if (read_request) begin
      case (rw_address)
        uart_pkg::uart_read_addr: begin
          read_data <= {24'b0, rx_byte};
        end
        uart_pkg::uart_status_addr: begin
          read_data <= {30'b0, rx_pending, tx_ready};
        end
        uart_pkg::uart_baud_addr: begin
          read_data <= baud_divisor;
        end
        // Write-only data register and unknown addresses read zero
        default: begin
          read_data <= '0;
        end
      endcase
    end
  end

endmodule

//--- uart_rx.sv
// UART receive deserializer
`timescale 1ns/1ps

module uart_rx (
  input  logic           clock,
  input  logic           reset_n,
  input  uart_pkg::baud_t baud_divisor,
  input  logic           uart_rx,
  input  logic           rx_ack,
  output uart_pkg::byte_t rx_byte,
  output logic           rx_pending
);

  uart_pkg::rx_state_t state;
  uart_pkg::baud_t     cycle_count;
  uart_pkg::baud_t     half_bit;
  logic [3:0]          bit_count;
  uart_pkg::byte_t     shift_reg;
  logic                sample_now;
  logic                last_sample;

  assign half_bit    = {1'b0, baud_divisor[31:1]};
  assign sample_now  = (state == uart_pkg::rx_sample) && (cycle_count >= baud_divisor);
  // Ninth sample lands in the stop bit
  assign last_sample = (bit_count == 4'(uart_pkg::rx_data_bits));

  // ----------------------------------------------------------------------
  // Receive control
  // ----------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (!reset_n || baud_divisor == '0) begin
      state       <= uart_pkg::rx_hunt;
      cycle_count <= '0;
      bit_count   <= '0;
    end else begin
      case (state)
        uart_pkg::rx_hunt: begin
          // A high line restarts the count and rejects glitches
          if (uart_rx) begin
            cycle_count <= '0;
          end else if (cycle_count < half_bit) begin
            cycle_count <= cycle_count + 1'b1;
          end else begin
            cycle_count <= '0;
            bit_count   <= '0;
            state       <= uart_pkg::rx_sample;
          end
        end
        uart_pkg::rx_sample: begin
          if (!sample_now) begin
            cycle_count <= cycle_count + 1'b1;
          end else begin
            cycle_count <= '0;
            bit_count   <= bit_count + 1'b1;
            if (last_sample) begin
              state <= uart_pkg::rx_hold;
            end
          end
        end
        uart_pkg::rx_hold: begin
          // Line ignored until the data register is read
          if (rx_ack) begin
            cycle_count <= '0;
            state       <= uart_pkg::rx_hunt;
          end
        end
        default: begin
          state <= uart_pkg::rx_hunt;
        end
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Data path
  // ----------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (sample_now) begin
      if (last_sample) begin
        rx_byte <= shift_reg;
      end else begin
        // LSB arrives first
        shift_reg <= {uart_rx, shift_reg[7:1]};
      end
    end
  end

  assign rx_pending = (state == uart_pkg::rx_hold);

endmodule

//--- uart_top.sv
// UART peripheral top level
`timescale 1ns/1ps

module uart_top (
  input  logic           clock,
  input  logic           reset_n,
  input  uart_pkg::addr_t rw_address,
  input  uart_pkg::word_t write_data,
  input  logic           read_request,
  input  logic           write_request,
  input  logic           uart_rx,
  output uart_pkg::word_t read_data,
  output logic           read_response,
  output logic           write_response,
  output logic           uart_tx,
  output logic           uart_irq
);

  uart_pkg::baud_t baud_divisor;
  logic            tx_start;
  uart_pkg::byte_t tx_byte;
  logic            tx_ready;
  logic            rx_ack;
  uart_pkg::byte_t rx_byte;

  // Register port and control
  uart_regs u_regs (
    .clock          (clock),
    .reset_n        (reset_n),
    .rw_address     (rw_address),
    .write_data     (write_data),
    .read_request   (read_request),
    .write_request  (write_request),
    .tx_ready       (tx_ready),
    .rx_byte        (rx_byte),
    .rx_pending     (uart_irq),
    .read_data      (read_data),
    .read_response  (read_response),
    .write_response (write_response),
    .baud_divisor   (baud_divisor),
    .tx_start       (tx_start),
    .tx_byte        (tx_byte),
    .rx_ack         (rx_ack)
  );

  // Serial datapaths
  uart_tx u_tx (
    .clock        (clock),
    .reset_n      (reset_n),
    .baud_divisor (baud_divisor),
    .tx_start     (tx_start),
    .tx_byte      (tx_byte),
    .uart_tx      (uart_tx),
    .tx_ready     (tx_ready)
  );

  uart_rx u_rx (
    .clock        (clock),
    .reset_n      (reset_n),
    .baud_divisor (baud_divisor),
    .uart_rx      (uart_rx),
    .rx_ack       (rx_ack),
    .rx_byte      (rx_byte),
    .rx_pending   (uart_irq)
  );

endmodule

//--- uart_tx.sv
// UART transmit serializer
`timescale 1ns/1ps

module uart_tx (
  input  logic           clock,
  input  logic           reset_n,
  input  uart_pkg::baud_t baud_divisor,
  input  logic           tx_start,
  input  uart_pkg::byte_t tx_byte,
  output logic           uart_tx,
  output logic           tx_ready
);

  uart_pkg::tx_state_t state;
  uart_pkg::baud_t     cycle_count;
  logic [3:0]          bit_count;
  logic [9:0]          shift_reg;

  // End of the current bit period
  logic bit_done;

  assign bit_done = (cycle_count >= baud_divisor);

  // ----------------------------------------------------------------------
  // Frame sequencing
  // ----------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (!reset_n || baud_divisor == '0) begin
      state       <= uart_pkg::tx_idle;
      cycle_count <= '0;
      bit_count   <= '0;
      shift_reg   <= '1;
    end else begin
      case (state)
        uart_pkg::tx_idle: begin
          if (tx_start) begin
            // Stop bit, data LSB first, start bit at the line end
            shift_reg   <= {1'b1, tx_byte, 1'b0};
            cycle_count <= '0;
            bit_count   <= '0;
            state       <= uart_pkg::tx_shift;
          end
        end
        uart_pkg::tx_shift: begin
          if (!bit_done) begin
            cycle_count <= cycle_count + 1'b1;
          end else begin
            cycle_count <= '0;
            // Shift in ones so the line rests high
            shift_reg   <= {1'b1, shift_reg[9:1]};
            bit_count   <= bit_count + 1'b1;
            if (bit_count == 4'(uart_pkg::tx_frame_bits - 1)) begin
              state <= uart_pkg::tx_idle;
            end
          end
        end
        default: begin
          state <= uart_pkg::tx_idle;
        end
      endcase
    end
  end

  assign uart_tx  = shift_reg[0];
  assign tx_ready = (state == uart_pkg::tx_idle);

endmodule

//--- vlog.f
uart_pkg.sv
uart_regs.sv
uart_tx.sv
uart_rx.sv
uart_top.sv
uart_chk.sv
tb_uart.sv
